//--- Makefile
# Verilator build and run for the backend testbench

TOP := backend_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/stl_reg.sv
hdl/lsu.sv
hdl/wbu.sv
hdl/regfile.sv
hdl/backend_top.sv
bench/tb_clkgen.sv
bench/backend_asserts.sv
bench/backend_tb.sv

//--- bench/backend_asserts.sv
`include "cpu_cfg.svh"

// handshake and register file properties bound onto the backend top level
module backend_asserts (
  input logic                  i_clk,
  input logic                  i_rst_n,
  input logic                  i_valid,
  input logic                  i_ready,
  input logic                  i_commit_valid,
  input logic                  i_wb_wen,
  input logic [`REG_ADDRW-1:0] i_rs_id,
  input logic [`CPU_WIDTH-1:0] i_rs_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // failures so far, read by the testbench
  int n_fail = 0;

  // accepted at one edge and retired two edges later
  a_commit_latency: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) (i_valid && i_ready) |-> ##2 i_commit_valid
  ) else begin
    $error("commit did not follow an accepted item by two cycles");
    n_fail++;
  end

  // empty pipe takes input straight away
  a_ready_after_reset: assert property (
    @(posedge i_clk) $rose(i_rst_n) |-> i_ready
  ) else begin
    $error("input not ready on leaving reset");
    n_fail++;
  end

  // register write only from a retiring item
  a_wen_needs_commit: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_wb_wen |-> i_commit_valid
  ) else begin
    $error("register write without commit valid");
    n_fail++;
  end

  // x0 hardwired
  a_x0_zero: assert property (
    @(posedge i_clk) (i_rs_id == '0) |-> (i_rs_data == '0)
  ) else begin
    $error("x0 read back nonzero");
    n_fail++;
  end

endmodule

bind backend_top backend_asserts u_asserts (
  .i_clk          (i_clk),
  .i_rst_n        (i_rst_n),
  .i_valid        (i_valid),
  .i_ready        (o_ready),
  .i_commit_valid (o_commit_valid),
  .i_wb_wen       (wb.wen),
  .i_rs_id        (i_rs_id),
  .i_rs_data      (o_rs_data)
);

//--- bench/backend_tb.sv
`include "cpu_cfg.svh"

module backend_tb
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAW     = $clog2(`DMEM_WORDS);
  localparam int TIMEOUT = 100;

  logic                  i_clk;
  logic                  i_rst_n;
  logic                  i_valid;
  logic                  o_ready;
  exu_res_t              i_exu;
  logic [`REG_ADDRW-1:0] i_rs_id;
  logic [`CPU_WIDTH-1:0] o_rs_data;
  logic                  o_commit_valid;
  logic [`CPU_WIDTH-1:0] o_commit_pc;

  // reference state in program order
  logic [`CPU_WIDTH-1:0] ref_regs [32];
  logic [`CPU_WIDTH-1:0] ref_mem [`DMEM_WORDS];
  // accepted items waiting to retire
  logic [`CPU_WIDTH-1:0] exp_pc [$];
  int                    exp_cyc [$];

  logic [`CPU_WIDTH-1:0] pc_next;
  int cyc;
  int n_checks;
  int n_errs;
  int pc_checks;
  int pc_errs;
  int test_base;

  ls_op_e ld_ops [5]  = '{LB, LBU, LH, LHU, LW};
  ls_op_e all_ops [9] = '{NONE, LB, LH, LW, LBU, LHU, SB, SH, SW};

  tb_clkgen u_clkgen (
    .o_clk   (i_clk),
    .o_rst_n (i_rst_n)
  );

  backend_top UUT (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_exu          (i_exu),
    .i_rs_id        (i_rs_id),
    .o_rs_data      (o_rs_data),
    .o_commit_valid (o_commit_valid),
    .o_commit_pc    (o_commit_pc)
  );

  // rising edges seen, read only at falling edges
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
  end

  function automatic int total_errs();
    return n_errs + pc_errs + UUT.u_asserts.n_fail;
  endfunction

  task automatic give_up(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic check_word(input string name, input logic [`CPU_WIDTH-1:0] got,
                            input logic [`CPU_WIDTH-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errs++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  // only the compare process calls this
  task automatic check_pc(input logic [`CPU_WIDTH-1:0] got, input logic [`CPU_WIDTH-1:0] exp);
    pc_checks++;
    if (got !== exp) begin
      pc_errs++;
      $display("Fail o_commit_pc got %h expected %h", got, exp);
    end
  endtask

  // load extension or alu result as the register should receive it
  function automatic logic [`CPU_WIDTH-1:0] ref_result(input exu_res_t e,
                                                      input logic [`CPU_WIDTH-1:0] word);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(word >> (8 * e.exres[1:0]));
    // half select by address bit 1, bit 0 dropped
    h = 16'(word >> (16 * e.exres[1]));
    case (e.op)
      LB:      return {{(`CPU_WIDTH-8){b[7]}}, b};
      LBU:     return {{(`CPU_WIDTH-8){1'b0}}, b};
      LH:      return {{(`CPU_WIDTH-16){h[15]}}, h};
      LHU:     return {{(`CPU_WIDTH-16){1'b0}}, h};
      LW:      return word;
      default: return e.exres;
    endcase
  endfunction

  // memory word after the item's store
  function automatic logic [`CPU_WIDTH-1:0] ref_merge(input exu_res_t e,
                                                     input logic [`CPU_WIDTH-1:0] old);
    logic [`CPU_WIDTH-1:0] mask;
    logic [`CPU_WIDTH-1:0] data;
    mask = '0;
    data = '0;
    case (e.op)
      SB: begin
        mask = 32'h0000_00ff << (8 * e.exres[1:0]);
        data = (e.stdata & 32'h0000_00ff) << (8 * e.exres[1:0]);
      end
      SH: begin
        mask = 32'h0000_ffff << (16 * e.exres[1]);
        data = (e.stdata & 32'h0000_ffff) << (16 * e.exres[1]);
      end
      SW: begin
        mask = '1;
        data = e.stdata;
      end
      default: begin
        mask = '0;
      end
    endcase
    return (old & ~mask) | (data & mask);
  endfunction

  // initial memory contents spread over every address bit
  function automatic logic [`CPU_WIDTH-1:0] fill_word(input logic [`CPU_WIDTH-1:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h5a3c_96e1;
  endfunction

  function automatic exu_res_t make_item(input ls_op_e op, input logic [`CPU_WIDTH-1:0] addr,
                                         input logic [`CPU_WIDTH-1:0] sd, input int rd,
                                         input logic wen);
    exu_res_t e;
    e        = '0;
    e.exres  = addr;
    e.stdata = sd;
    e.rdid   = rd[`REG_ADDRW-1:0];
    e.rdwen  = wen;
    e.op     = op;
    return e;
  endfunction

  // update the model at acceptance and queue the retire
  task automatic model_apply(input exu_res_t e);
    logic [MAW-1:0]        wi;
    logic [`CPU_WIDTH-1:0] val;
    wi          = e.exres[MAW+1:2];
    val         = ref_result(e, ref_mem[wi]);
    ref_mem[wi] = ref_merge(e, ref_mem[wi]);
    if (e.rdwen && e.rdid != '0) begin
      ref_regs[e.rdid] = val;
    end
    exp_pc.push_back(e.pc);
    exp_cyc.push_back(cyc);
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send(input exu_res_t e);
    exu_res_t x;
    int       t;
    x       = e;
    x.pc    = pc_next;
    pc_next = pc_next + 4;
    i_valid = 1'b1;
    i_exu   = x;
    t       = 0;
    // ready seen mid-cycle means transfer on the next rising edge
    @(negedge i_clk);
    while (!o_ready) begin
      t++;
      if (t > TIMEOUT) begin
        give_up("timeout waiting for o_ready");
      end
      @(negedge i_clk);
    end
    model_apply(x);
    @(posedge i_clk);
    #1;
    i_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // returns 1 ns after the edge that writes the last retired item
  task automatic drain();
    int t;
    t = 0;
    while (exp_pc.size() != 0) begin
      t++;
      if (t > TIMEOUT) begin
        give_up("timeout waiting for in-flight items to retire");
      end
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
  endtask

  // address driven now, data checked mid-cycle
  task automatic read_reg(input int idx);
    i_rs_id = idx[`REG_ADDRW-1:0];
    @(negedge i_clk);
    check_word($sformatf("o_rs_data x%0d", idx), o_rs_data, ref_regs[idx[`REG_ADDRW-1:0]]);
    @(posedge i_clk);
    #1;
  endtask

  task automatic load_check(input ls_op_e op, input logic [`CPU_WIDTH-1:0] addr);
    int rd;
    rd = $urandom_range(31, 1);
    send(make_item(op, addr, '0, rd, 1'b1));
    drain();
    read_reg(rd);
  endtask

  task automatic end_test(input string name);
    $display("test %s  %0d errors", name, total_errs() - test_base);
    test_base = total_errs();
  endtask

  // retire order and latency against the accepted items
  always @(negedge i_clk) begin
    int acc;
    if (i_rst_n && o_commit_valid) begin
      if (exp_pc.size() == 0) begin
        pc_checks++;
        pc_errs++;
        $display("commit of pc %h with no item in flight", o_commit_pc);
      end else begin
        check_pc(o_commit_pc, exp_pc.pop_front());
        acc = exp_cyc.pop_front();
        pc_checks++;
        if (cyc != acc + 2) begin
          pc_errs++;
          $display("commit of pc %h came %0d cycles after acceptance", o_commit_pc, cyc - acc);
        end
      end
    end
  end

  initial begin
    logic [`CPU_WIDTH-1:0] addr;
    int                    rd;
    int                    t;
    void'($urandom(32'h7e97_064e));
    i_valid   = 1'b0;
    i_exu     = '0;
    i_rs_id   = '0;
    pc_next   = 32'h0000_1000;
    cyc       = 0;
    n_checks  = 0;
    n_errs    = 0;
    pc_checks = 0;
    pc_errs   = 0;
    test_base = 0;
    ref_regs  = '{default: '0};

    t = 0;
    while (i_rst_n !== 1'b1) begin
      t++;
      if (t > TIMEOUT) begin
        give_up("timeout waiting for reset release");
      end
      @(posedge i_clk);
    end
    #1;

    // pipe empty and every register cleared
    @(negedge i_clk);
    check_flag("o_commit_valid", o_commit_valid, 1'b0);
    check_flag("o_ready", o_ready, 1'b1);
    @(posedge i_clk);
    #1;
    for (int r = 0; r < 32; r++) begin
      read_reg(r);
    end
    end_test("1 reset");

    // alu results to random registers with x0 among them
    for (int k = 0; k < 12; k++) begin
      rd = $urandom_range(31, 0);
      send(make_item(NONE, $urandom, '0, rd, 1'b1));
      drain();
      read_reg(rd);
      read_reg(0);
    end
    end_test("2 alu writeback");

    // fill words 0 to 15 then partial stores and each load kind
    for (int a = 0; a < 64; a += 4) begin
      send(make_item(SW, a, fill_word(a), 0, 1'b0));
    end
    for (int k = 0; k < 4; k++) begin
      send(make_item(SB, 4 * k + k, $urandom, 0, 1'b0));
      send(make_item(SH, 32 + 4 * k + k, $urandom, 0, 1'b0));
    end
    drain();
    for (int a = 0; a < 8; a++) begin
      for (int j = 0; j < 5; j++) begin
        load_check(ld_ops[j], a);
        load_check(ld_ops[j], 32 + a);
      end
    end
    end_test("3 loads and stores");

    // load right behind a store to the same address
    for (int k = 0; k < 6; k++) begin
      addr = $urandom & 32'h3f;
      rd   = $urandom_range(31, 1);
      send(make_item(k[0] ? SB : SW, addr, $urandom, 0, 1'b0));
      send(make_item(k[0] ? LBU : LW, addr, '0, rd, 1'b1));
      drain();
      read_reg(rd);
    end
    end_test("4 store then load");

    // random mix with gaps then a full register sweep
    for (int n = 0; n < 60; n++) begin
      send(make_item(all_ops[$urandom_range(8, 0)], $urandom & 32'h3f, $urandom,
                     $urandom_range(31, 0), $urandom_range(1, 0) == 1));
      idle($urandom_range(2, 0));
    end
    drain();
    for (int r = 0; r < 32; r++) begin
      read_reg(r);
    end
    end_test("5 random mix");

    $display("%0d checks  %0d errors", n_checks + pc_checks, total_errs());
    if (total_errs() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/tb_clkgen.sv
// free running clock and power-on reset for the testbench
module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #2 o_clk = ~o_clk;
    end
  end

  // held low over two rising edges and released just after the second
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #1 o_rst_n = 1'b1;
  end

endmodule

//--- hdl/backend_top.sv
`include "cpu_cfg.svh"

module backend_top
  import cpu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  // execute result in
  input  logic                  i_valid,
  output logic                  o_ready,
  input  exu_res_t              i_exu,
  // decode operand read
  input  logic [`REG_ADDRW-1:0] i_rs_id,
  output logic [`CPU_WIDTH-1:0] o_rs_data,
  // retire info
  output logic                  o_commit_valid,
  output logic [`CPU_WIDTH-1:0] o_commit_pc
);

  // lsu to wbu
  logic     lsu_valid;
  logic     wbu_ready;
  lsu_res_t lsu_res;
  // wbu to register file
  wb_t      wb;

  lsu u_lsu (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pre_valid  (i_valid),
    .o_pre_ready  (o_ready),
    .i_exu        (i_exu),
    .o_post_valid (lsu_valid),
    .i_post_ready (wbu_ready),
    .o_lsu        (lsu_res)
  );

  wbu u_wbu (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_pre_valid    (lsu_valid),
    .o_pre_ready    (wbu_ready),
    .i_lsu          (lsu_res),
    .o_wb           (wb),
    .o_commit_valid (o_commit_valid),
    .o_commit_pc    (o_commit_pc)
  );

  regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wb      (wb),
    .i_rs_id   (i_rs_id),
    .o_rs_data (o_rs_data)
  );

endmodule

//--- hdl/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath width for data and addresses, rv32
`define CPU_WIDTH 32

// register index width
// 5 bits address x0..x31
`define REG_ADDRW 5

// data memory depth in words
// the byte address is aligned down to a word before indexing
`define DMEM_WORDS 256

`endif

//--- hdl/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  // memory operation carried with each execute result
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LH   = 4'd2,
    LW   = 4'd3,
    LBU  = 4'd4,
    LHU  = 4'd5,
    SB   = 4'd6,
    SH   = 4'd7,
    SW   = 4'd8
  } ls_op_e;

  // execute result entering the memory-access stage
  typedef struct packed {
    // alu result, also the memory address
    logic [`CPU_WIDTH-1:0] exres;
    // store data, low lanes used for byte and half
    logic [`CPU_WIDTH-1:0] stdata;
    logic [`REG_ADDRW-1:0] rdid;
    logic                  rdwen;
    ls_op_e                op;
    logic [`CPU_WIDTH-1:0] pc;
  } exu_res_t;

  // memory-access result handed to writeback
  typedef struct packed {
    logic [`CPU_WIDTH-1:0] exres;
    // extended load data
    logic [`CPU_WIDTH-1:0] lsres;
    logic [`REG_ADDRW-1:0] rdid;
    logic                  rdwen;
    // set when lsres is the value to write back
    logic                  lden;
    logic [`CPU_WIDTH-1:0] pc;
  } lsu_res_t;

  // register file write
  typedef struct packed {
    logic                  wen;
    logic [`REG_ADDRW-1:0] rdid;
    logic [`CPU_WIDTH-1:0] rd;
  } wb_t;

endpackage

//--- hdl/lsu.sv
`include "cpu_cfg.svh"

module lsu
  import cpu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst_n,
  // handshake with the execute side
  input  logic     i_pre_valid,
  output logic     o_pre_ready,
  input  exu_res_t i_exu,
  // handshake with writeback
  output logic     o_post_valid,
  input  logic     i_post_ready,
  output lsu_res_t o_lsu
);

  localparam int DMEM_AW = $clog2(`DMEM_WORDS);

  logic                  post_valid;
  logic                  pre_sh;
  logic                  post_sh;
  exu_res_t              exu_r;

  logic [`CPU_WIDTH-1:0] dmem [`DMEM_WORDS];
  logic [DMEM_AW-1:0]    word_idx;
  logic [1:0]            byte_off;
  logic [`CPU_WIDTH-1:0] rdata;

  logic [3:0]            st_be;
  logic [`CPU_WIDTH-1:0] st_lanes;
  logic [`CPU_WIDTH-1:0] st_mask;
  logic [`CPU_WIDTH-1:0] st_word;
  logic                  st_en;

  logic [7:0]            ld_byte;
  logic [15:0]           ld_half;
  logic [`CPU_WIDTH-1:0] ld_data;

  // ready when empty or when the held item leaves this cycle
  assign o_pre_ready  = post_valid & i_post_ready | !post_valid;
  assign pre_sh       = i_pre_valid & o_pre_ready;
  assign post_sh      = post_valid & i_post_ready;
  assign o_post_valid = post_valid;

  // payload only moves on a transfer
  stl_reg #(
    .T         (exu_res_t),
    .RESET_VAL ('0)
  ) u_payload (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wen   (pre_sh),
    .i_din   (i_exu),
    .o_dout  (exu_r)
  );

  // valid follows the incoming valid whenever ready is high
  stl_reg #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_valid (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wen   (o_pre_ready),
    .i_din   (i_pre_valid),
    .o_dout  (post_valid)
  );

  // misaligned low bits are dropped, access aligned down
  assign word_idx = exu_r.exres[DMEM_AW+1:2];
  assign byte_off = exu_r.exres[1:0];
  // async read from the registered address
  assign rdata    = dmem[word_idx];

  // byte enables and replicated store lanes
  always_comb begin
    st_be    = 4'b0000;
    st_lanes = exu_r.stdata;
    case (exu_r.op)
      SB: begin
        st_be    = 4'b0001 << byte_off;
        st_lanes = {4{exu_r.stdata[7:0]}};
      end
      SH: begin
        st_be    = byte_off[1] ? 4'b1100 : 4'b0011;
        st_lanes = {2{exu_r.stdata[15:0]}};
      end
      SW: begin
        st_be    = 4'b1111;
      end
      default: begin
        st_be    = 4'b0000;
      end
    endcase
  end

  // expand enables to a bit mask and merge into the old word
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      st_mask[8*i +: 8] = {8{st_be[i]}};
    end
  end

  assign st_word = (rdata & ~st_mask) | (st_lanes & st_mask);
  // write lands on the edge where the store leaves the stage
  assign st_en   = post_sh & (st_be != 4'b0000);

  always_ff @(posedge i_clk) begin
    if (st_en) begin
      dmem[word_idx] <= st_word;
    end
  end

  // load lane select
  assign ld_byte = rdata[8*byte_off +: 8];
  assign ld_half = byte_off[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (exu_r.op)
      LB:      ld_data = {{(`CPU_WIDTH-8){ld_byte[7]}}, ld_byte};
      LBU:     ld_data = {{(`CPU_WIDTH-8){1'b0}}, ld_byte};
      LH:      ld_data = {{(`CPU_WIDTH-16){ld_half[15]}}, ld_half};
      LHU:     ld_data = {{(`CPU_WIDTH-16){1'b0}}, ld_half};
      LW:      ld_data = rdata;
      default: ld_data = '0;
    endcase
  end

  assign o_lsu.exres = exu_r.exres;
  assign o_lsu.lsres = ld_data;
  assign o_lsu.rdid  = exu_r.rdid;
  assign o_lsu.rdwen = exu_r.rdwen;
  assign o_lsu.lden  = exu_r.op inside {LB, LH, LW, LBU, LHU};
  assign o_lsu.pc    = exu_r.pc;

endmodule

//--- hdl/regfile.sv
`include "cpu_cfg.svh"

module regfile
  import cpu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  wb_t                   i_wb,
  // operand read for decode
  input  logic [`REG_ADDRW-1:0] i_rs_id,
  output logic [`CPU_WIDTH-1:0] o_rs_data
);

  localparam int NREGS = 1 << `REG_ADDRW;

  logic [`CPU_WIDTH-1:0] regs [NREGS];

  // x0 is never written
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && (i_wb.rdid != '0)) begin
      regs[i_wb.rdid] <= i_wb.rd;
    end
  end

  // read sees the written value from the edge after the write
  assign o_rs_data = (i_rs_id == '0) ? '0 : regs[i_rs_id];

endmodule

//--- hdl/stl_reg.sv
// generic pipe register
// the same block holds stage payloads and the single valid bits
module stl_reg #(
  parameter type T         = logic,
  parameter T    RESET_VAL = '0
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_wen,
  input  T     i_din,
  output T     o_dout
);

  // load on enable, hold otherwise
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dout <= RESET_VAL;
    end else if (i_wen) begin
      o_dout <= i_din;
    end
  end

endmodule

//--- hdl/wbu.sv
`include "cpu_cfg.svh"

module wbu
  import cpu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_pre_valid,
  output logic                  o_pre_ready,
  input  lsu_res_t              i_lsu,
  output wb_t                   o_wb,
  output logic                  o_commit_valid,
  output logic [`CPU_WIDTH-1:0] o_commit_pc
);

  logic     post_valid;
  logic     post_ready;
  logic     pre_sh;
  lsu_res_t lsu_r;

  // register file takes a write every cycle
  assign post_ready  = 1'b1;
  assign o_pre_ready = post_valid & post_ready | !post_valid;
  assign pre_sh      = i_pre_valid & o_pre_ready;

  stl_reg #(
    .T         (lsu_res_t),
    .RESET_VAL ('0)
  ) u_payload (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wen   (pre_sh),
    .i_din   (i_lsu),
    .o_dout  (lsu_r)
  );

  stl_reg #(
    .T         (logic),
    .RESET_VAL (1'b0)
  ) u_valid (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wen   (o_pre_ready),
    .i_din   (i_pre_valid),
    .o_dout  (post_valid)
  );

  // load data wins when lden, else the alu result
  assign o_wb.rd   = lsu_r.lden ? lsu_r.lsres : lsu_r.exres;
  assign o_wb.rdid = lsu_r.rdid;
  // a stale payload never writes
  assign o_wb.wen  = post_valid & post_ready & lsu_r.rdwen;

  // every item leaving here retires
  assign o_commit_valid = post_valid & post_ready;
  assign o_commit_pc    = lsu_r.pc;

endmodule
